// File: source/lcd_test_settings.svh
`ifndef LCD_TEST_SETTINGS_SVH
`define LCD_TEST_SETTINGS_SVH

// --------------------
// display geometry
// --------------------

// default active area, overridden by parameter where needed
`define LCD_H_DISP 640
`define LCD_V_DISP 480

// coordinate width, covers up to 2047 pixels per axis
`define LCD_POS_W 11

// --------------------
// pixel format
// --------------------

// rgb 8|8|8
`define LCD_RGB_W 24

// grid line where low bits of x or y are zero
`define LCD_GRID_BITS 3

`endif

// File: source/lcd_test_pkg.sv
`default_nettype none

`include "lcd_test_settings.svh"

package lcd_test_pkg;

    // pattern select
    // code 3 unused, falls back to bars
    typedef enum logic [1:0] {
        PAT_BARS = 2'd0,
        PAT_GRID = 2'd1,
        PAT_RAMP = 2'd2
    } pattern_t;

    // --------------------
    // pipeline payloads
    // --------------------

    // scanner output, one raster position
    typedef struct packed {
        logic [`LCD_POS_W-1:0] x;
        logic [`LCD_POS_W-1:0] y;
        logic [7:0]            frame;
        logic                  first;   // pixel (0,0)
    } pixel_pos_t;

    // colour stage output
    typedef struct packed {
        logic [`LCD_POS_W-1:0] x;
        logic [`LCD_POS_W-1:0] y;
        logic                  first;
        logic [`LCD_RGB_W-1:0] rgb;
    } pixel_rgb_t;

    // write request towards sdram controller
    typedef struct packed {
        logic [31:0]           addr;
        logic [`LCD_RGB_W-1:0] data;
        logic                  first;   // controller reloads write address
    } pixel_wr_t;

endpackage

`default_nettype wire

// File: source/pipe_reg.sv
`timescale 1ns/1ns
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,

    // upstream side
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    // downstream side
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic load;

    // free slot, or slot drains this cycle
    assign in_ready = !out_valid || out_ready;
    assign load     = in_valid && in_ready;

    // occupancy flag
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            out_valid <= 1'b0;
        else if (load)
            out_valid <= 1'b1;
        else if (out_ready)
            out_valid <= 1'b0;
    end

    // payload, only written on accept
    always_ff @(posedge clk)
    begin
        if (load)
            out_data <= in_data;
    end

endmodule

`default_nettype wire

// File: source/pixel_scan.sv
`timescale 1ns/1ns
`default_nettype none

`include "lcd_test_settings.svh"

module pixel_scan #(
    parameter int H_DISP = `LCD_H_DISP,
    parameter int V_DISP = `LCD_V_DISP
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    sdram_ready,
    input  logic [7:0]              divide,

    output logic                    pos_valid,
    input  logic                    pos_ready,
    output lcd_test_pkg::pixel_pos_t pos
);

    localparam int POS_W = `LCD_POS_W;
    localparam logic [POS_W-1:0] X_LAST = POS_W'(H_DISP - 1);
    localparam logic [POS_W-1:0] Y_LAST = POS_W'(V_DISP - 1);

    logic [7:0]       pace_cnt;
    logic [POS_W-1:0] x_cnt;
    logic [POS_W-1:0] y_cnt;
    logic [7:0]       frame_cnt;
    logic             issue;

    // --------------------
    // pacing
    // --------------------

    // 0..divide then wrap, >= guards a late shrink of divide
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            pace_cnt <= 8'd0;
        else if (pace_cnt >= divide)
            pace_cnt <= 8'd0;
        else
            pace_cnt <= pace_cnt + 8'd1;
    end

    // slot lost if sdram not up or output still held
    assign issue = (pace_cnt == 8'd0) && sdram_ready && (!pos_valid || pos_ready);

    // --------------------
    // raster counters
    // --------------------

    // x first, then y, frame count on wrap
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            x_cnt     <= '0;
            y_cnt     <= '0;
            frame_cnt <= 8'd0;
        end
        else if (issue)
        begin
            if (x_cnt == X_LAST)
            begin
                x_cnt <= '0;
                if (y_cnt == Y_LAST)
                begin
                    y_cnt     <= '0;
                    frame_cnt <= frame_cnt + 8'd1;
                end
                else
                    y_cnt <= y_cnt + 1'b1;
            end
            else
                x_cnt <= x_cnt + 1'b1;
        end
    end

    // output slot valid
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            pos_valid <= 1'b0;
        else if (issue)
            pos_valid <= 1'b1;
        else if (pos_ready)
            pos_valid <= 1'b0;
    end

    // output payload
    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            pos.x     <= x_cnt;
            pos.y     <= y_cnt;
            pos.frame <= frame_cnt;
            pos.first <= (x_cnt == '0) && (y_cnt == '0);
        end
    end

endmodule

`default_nettype wire

// File: source/pattern_color.sv
`timescale 1ns/1ns
`default_nettype none

`include "lcd_test_settings.svh"

module pattern_color #(
    parameter int H_DISP = `LCD_H_DISP
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  lcd_test_pkg::pattern_t   pattern_sel,

    input  logic                     pos_valid,
    output logic                     pos_ready,
    input  lcd_test_pkg::pixel_pos_t pos,

    output logic                     pix_valid,
    input  logic                     pix_ready,
    output lcd_test_pkg::pixel_rgb_t pix
);

    // --------------------
    // bar colours, rgb 8|8|8
    // --------------------
    localparam logic [23:0] RED     = 24'hFF0000;
    localparam logic [23:0] GREEN   = 24'h00FF00;
    localparam logic [23:0] BLUE    = 24'h0000FF;
    localparam logic [23:0] WHITE   = 24'hFFFFFF;
    localparam logic [23:0] BLACK   = 24'h000000;
    localparam logic [23:0] YELLOW  = 24'hFFFF00;
    localparam logic [23:0] MAGENTA = 24'hFF00FF;
    localparam logic [23:0] CYAN    = 24'h00FFFF;

    logic [31:0]              bar_num;
    logic                     on_grid;
    lcd_test_pkg::pixel_rgb_t pix_next;

    // eight equal bars across the line
    assign bar_num = (32'(pos.x) << 3) / 32'(H_DISP);

    // line every 2^GRID_BITS pixels
    assign on_grid = (pos.x[`LCD_GRID_BITS-1:0] == '0) ||
                     (pos.y[`LCD_GRID_BITS-1:0] == '0);

    always_comb
    begin
        pix_next.x     = pos.x;
        pix_next.y     = pos.y;
        pix_next.first = pos.first;
        case (pattern_sel)
            lcd_test_pkg::PAT_GRID: pix_next.rgb = on_grid ? WHITE : BLACK;
            // x | y | frame in the colour bytes
            lcd_test_pkg::PAT_RAMP: pix_next.rgb = {pos.x[7:0], pos.y[7:0], pos.frame};
            default:
            begin
                case (bar_num[2:0])
                    3'd0:    pix_next.rgb = RED;
                    3'd1:    pix_next.rgb = GREEN;
                    3'd2:    pix_next.rgb = BLUE;
                    3'd3:    pix_next.rgb = WHITE;
                    3'd4:    pix_next.rgb = BLACK;
                    3'd5:    pix_next.rgb = YELLOW;
                    3'd6:    pix_next.rgb = MAGENTA;
                    default: pix_next.rgb = CYAN;
                endcase
            end
        endcase
    end

    // one cycle stage, pattern_sel captured on accept
    pipe_reg #(.payload_t(lcd_test_pkg::pixel_rgb_t)) u_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (pos_valid),
        .in_ready  (pos_ready),
        .in_data   (pix_next),
        .out_valid (pix_valid),
        .out_ready (pix_ready),
        .out_data  (pix)
    );

endmodule

`default_nettype wire

// File: source/fb_addr_gen.sv
`timescale 1ns/1ns
`default_nettype none

`include "lcd_test_settings.svh"

module fb_addr_gen #(
    parameter int H_DISP = `LCD_H_DISP
) (
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic                     pix_valid,
    output logic                     pix_ready,
    input  lcd_test_pkg::pixel_rgb_t pix,

    output logic                     wr_valid,
    input  logic                     wr_ready,
    output lcd_test_pkg::pixel_wr_t  wr
);

    logic [31:0]             row_base;
    lcd_test_pkg::pixel_wr_t wr_next;

    // --------------------
    // linear address
    // --------------------

    // start of the line in the frame buffer
    assign row_base = 32'(pix.y) * 32'(H_DISP);

    always_comb
    begin
        wr_next.addr  = row_base + 32'(pix.x);
        wr_next.data  = pix.rgb;
        wr_next.first = pix.first;
    end

    // output slot toward the controller
    pipe_reg #(.payload_t(lcd_test_pkg::pixel_wr_t)) u_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (pix_valid),
        .in_ready  (pix_ready),
        .in_data   (wr_next),
        .out_valid (wr_valid),
        .out_ready (wr_ready),
        .out_data  (wr)
    );

endmodule

`default_nettype wire

// File: source/lcd_test_data.sv
`timescale 1ns/1ns
`default_nettype none

`include "lcd_test_settings.svh"

module lcd_test_data #(
    parameter int H_DISP = `LCD_H_DISP,
    parameter int V_DISP = `LCD_V_DISP
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    sdram_ready,
    input  logic [7:0]              divide,
    input  lcd_test_pkg::pattern_t  pattern_sel,

    // write request to sdram controller
    output logic                    wr_valid,
    input  logic                    wr_ready,
    output lcd_test_pkg::pixel_wr_t wr
);

    // --------------------
    // stage links
    // --------------------
    logic                     pos_valid;
    logic                     pos_ready;
    lcd_test_pkg::pixel_pos_t pos;
    logic                     pix_valid;
    logic                     pix_ready;
    lcd_test_pkg::pixel_rgb_t pix;

    // paced raster scan
    pixel_scan #(.H_DISP(H_DISP), .V_DISP(V_DISP)) u_scan (
        .clk         (clk),
        .rst_n       (rst_n),
        .sdram_ready (sdram_ready),
        .divide      (divide),
        .pos_valid   (pos_valid),
        .pos_ready   (pos_ready),
        .pos         (pos)
    );

    // position to colour
    pattern_color #(.H_DISP(H_DISP)) u_color (
        .clk         (clk),
        .rst_n       (rst_n),
        .pattern_sel (pattern_sel),
        .pos_valid   (pos_valid),
        .pos_ready   (pos_ready),
        .pos         (pos),
        .pix_valid   (pix_valid),
        .pix_ready   (pix_ready),
        .pix         (pix)
    );

    // colour to write request
    fb_addr_gen #(.H_DISP(H_DISP)) u_addr (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix_valid (pix_valid),
        .pix_ready (pix_ready),
        .pix       (pix),
        .wr_valid  (wr_valid),
        .wr_ready  (wr_ready),
        .wr        (wr)
    );

endmodule

`default_nettype wire

// File: sim/lcd_test_data_assert.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_test_data_assert (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    wr_valid,
    input logic                    wr_ready,
    input lcd_test_pkg::pixel_wr_t wr
);

    // number of failed handshake checks
    int fail_cnt = 0;

    // payload held while stalled
    wr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        wr_valid && !wr_ready |=> $stable(wr))
        else
        begin
            fail_cnt = fail_cnt + 1;
            $error("wr changed while wr_valid high and wr_ready low");
        end

    // valid only falls after a transfer
    wr_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
        wr_valid && !wr_ready |=> wr_valid)
        else
        begin
            fail_cnt = fail_cnt + 1;
            $error("wr_valid dropped without a transfer");
        end

    // nothing offered in reset
    wr_idle_in_reset: assert property (@(posedge clk)
        !rst_n |-> !wr_valid)
        else
        begin
            fail_cnt = fail_cnt + 1;
            $error("wr_valid high during reset");
        end

endmodule

bind lcd_test_data lcd_test_data_assert u_assert (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_valid (wr_valid),
    .wr_ready (wr_ready),
    .wr       (wr)
);

`default_nettype wire

// File: sim/lcd_test_data_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "lcd_test_settings.svh"

module lcd_test_data_tb;

    localparam int H = 16;
    localparam int V = 8;
    localparam int GRID = 1 << `LCD_GRID_BITS;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    sdram_ready;
    logic [7:0]              divide;
    lcd_test_pkg::pattern_t  pattern_sel;
    logic                    wr_valid;
    logic                    wr_ready;
    lcd_test_pkg::pixel_wr_t wr;

    // checker state for the expected raster position
    int exp_x = 0;
    int exp_y = 0;
    int exp_frame = 0;
    int accept_cnt = 0;
    int since_last = 0;
    int min_gap = 0;
    logic stall_en = 1'b0;

    lcd_test_data #(.H_DISP(H), .V_DISP(V)) u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .sdram_ready (sdram_ready),
        .divide      (divide),
        .pattern_sel (pattern_sel),
        .wr_valid    (wr_valid),
        .wr_ready    (wr_ready),
        .wr          (wr)
    );

    always #5 clk = ~clk;

    // --------------------
    // reference model
    // --------------------

    // expected write for one pixel from the pattern rules
    function automatic lcd_test_pkg::pixel_wr_t expected_write(
        input int x, input int y, input int frame, input lcd_test_pkg::pattern_t pat);
        lcd_test_pkg::pixel_wr_t res;
        int bar;
        res.addr  = 32'(y * H + x);
        res.first = (x == 0) && (y == 0);
        bar = (x * 8) / H;
        case (pat)
            lcd_test_pkg::PAT_GRID:
                res.data = ((x % GRID) == 0 || (y % GRID) == 0) ? 24'hFFFFFF : 24'h000000;
            lcd_test_pkg::PAT_RAMP:
                res.data = {8'(x), 8'(y), 8'(frame)};
            default:
            begin
                // red green blue white black yellow magenta cyan
                case (bar)
                    0:       res.data = 24'hFF0000;
                    1:       res.data = 24'h00FF00;
                    2:       res.data = 24'h0000FF;
                    3:       res.data = 24'hFFFFFF;
                    4:       res.data = 24'h000000;
                    5:       res.data = 24'hFFFF00;
                    6:       res.data = 24'hFF00FF;
                    default: res.data = 24'h00FFFF;
                endcase
            end
        endcase
        return res;
    endfunction

    // --------------------
    // error handling and compares
    // --------------------

    task automatic stop_on_error(input string why);
        $display("test failed");
        $fatal(1, "%s", why);
    endtask

    // field by field compare of one write request
    task automatic compare_write(input lcd_test_pkg::pixel_wr_t got,
                                 input lcd_test_pkg::pixel_wr_t exp);
        int bad;
        bad = 0;
        if (got.addr !== exp.addr)
        begin
            $display("Error at %0t ns: wr.addr = %0d, expected %0d", $time, got.addr, exp.addr);
            bad++;
        end
        if (got.data !== exp.data)
        begin
            $display("Error at %0t ns: wr.data = %06h, expected %06h", $time, got.data, exp.data);
            bad++;
        end
        if (got.first !== exp.first)
        begin
            $display("Error at %0t ns: wr.first = %b, expected %b", $time, got.first, exp.first);
            bad++;
        end
        if (bad != 0)
            stop_on_error("write request does not match the expected pixel");
    endtask

    task automatic match_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
            stop_on_error("single bit check failed");
        end
    endtask

    // --------------------
    // checker
    // --------------------

    // every accepted write against the model and advance raster
    always @(posedge clk)
    begin
        if (rst_n && wr_valid && wr_ready)
        begin
            compare_write(wr, expected_write(exp_x, exp_y, exp_frame, pattern_sel));
            if (min_gap != 0 && accept_cnt > 0)
                match_bit("write_spacing_ok", since_last >= min_gap, 1'b1);
            since_last = 1;
            accept_cnt = accept_cnt + 1;
            if (exp_x == H - 1)
            begin
                exp_x = 0;
                if (exp_y == V - 1)
                begin
                    exp_y = 0;
                    exp_frame = (exp_frame + 1) % 256;
                end
                else
                    exp_y = exp_y + 1;
            end
            else
                exp_x = exp_x + 1;
        end
        else
            since_last = since_last + 1;
    end

    // handshake assertions bound into the DUT
    always @(posedge clk)
    begin
        if (u_dut.u_assert.fail_cnt != 0)
            stop_on_error("a handshake assertion on the write port failed");
    end

    // back-pressure is random only in the stall phase
    initial
    begin
        void'($urandom(32'he139_db45));
        wr_ready = 1'b1;
        forever
        begin
            @(posedge clk);
            #1;
            wr_ready = stall_en ? (($urandom % 4) != 0) : 1'b1;
        end
    end

    // --------------------
    // stimulus
    // --------------------

    // wait for n more accepted writes
    task automatic wait_writes(input int n, input int limit);
        int target;
        int cycles;
        target = accept_cnt + n;
        cycles = 0;
        while (accept_cnt < target && cycles < limit)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (accept_cnt < target)
            stop_on_error("timed out waiting for write requests");
    endtask

    // stop the scanner and let the pipeline empty
    task automatic drain();
        int idle;
        int cycles;
        sdram_ready = 1'b0;
        idle = 0;
        cycles = 0;
        while (idle < 8 && cycles < 200)
        begin
            @(posedge clk);
            #1;
            cycles++;
            idle = wr_valid ? 0 : idle + 1;
        end
        if (idle < 8)
            stop_on_error("pipeline did not drain after sdram_ready dropped");
    endtask

    initial
    begin
        rst_n       = 1'b0;
        sdram_ready = 1'b0;
        divide      = 8'd0;
        pattern_sel = lcd_test_pkg::PAT_BARS;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // idle while sdram not ready
        for (int i = 0; i < 200; i++)
        begin
            @(posedge clk);
            #1;
            match_bit("wr_valid", wr_valid, 1'b0);
        end

        // bars for two full frames at full rate
        sdram_ready = 1'b1;
        wait_writes(2 * H * V, 2000);
        drain();

        // grid paced at one pixel per 4 cycles
        pattern_sel = lcd_test_pkg::PAT_GRID;
        divide      = 8'd3;
        min_gap     = 4;
        sdram_ready = 1'b1;
        wait_writes(H * V, 3000);
        drain();
        min_gap = 0;

        // ramp over three frames with frame count in blue
        pattern_sel = lcd_test_pkg::PAT_RAMP;
        divide      = 8'd1;
        sdram_ready = 1'b1;
        wait_writes(3 * H * V, 4000);
        drain();

        // random stalls at full rate
        divide      = 8'd0;
        stall_en    = 1'b1;
        sdram_ready = 1'b1;
        wait_writes(2 * H * V, 4000);
        stall_en = 1'b0;
        drain();

        if (u_dut.u_assert.fail_cnt != 0)
            stop_on_error("a handshake assertion on the write port failed");
        else
        begin
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+source
source/lcd_test_pkg.sv
source/pipe_reg.sv
source/pixel_scan.sv
source/pattern_color.sv
source/fb_addr_gen.sv
source/lcd_test_data.sv
sim/lcd_test_data_assert.sv
sim/lcd_test_data_tb.sv

// File: Bender.yml
package:
  name: lcd_test_data

sources:
  - include_dirs:
      - source
    files:
      - source/lcd_test_pkg.sv
      - source/pipe_reg.sv
      - source/pixel_scan.sv
      - source/pattern_color.sv
      - source/fb_addr_gen.sv
      - source/lcd_test_data.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/lcd_test_data_assert.sv
      - sim/lcd_test_data_tb.sv
